/* verilog.f */
+incdir+common
common/priv_pkg.sv
csr/irq_arbiter.sv
csr/trap_ctrl.sv
csr/csr_regfile.sv
source/priv_unit.sv
dv/priv_unit_tb.sv

/* Makefile */
TOP = priv_unit_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee run.log
	grep -q "Simulation PASSED" run.log

clean:
	rm -rf obj_dir run.log

/* dv/priv_unit_tb.sv */
`timescale 1ns/1ps
`include "priv_cfg.svh"

module priv_unit_tb import priv_pkg::*; ();

    localparam int    clk_period   = 100;
    localparam int    num_tests    = 5;
    localparam int    test_cycles  = 60;
    localparam int    reset_cycles = 4;
    localparam word_t csr_inst     = 32'h3000_2573;   // csrr a0, mstatus
    localparam word_t fault_addr   = 32'h8000_1234;

    logic       clk;
    logic       rst;
    csr_addr_t  raddr;
    csr_addr_t  waddr;
    logic       we;
    word_t      wdata;
    exc_flags_t exc_flags;
    logic       mret;
    logic       sret;
    word_t      inst;
    word_t      pc;
    word_t      mem_addr;
    logic       timer_irq;
    logic       ext_irq;
    word_t      rdata;
    priv_mode_t cpu_mode;
    priv_mode_t lsu_mode;
    logic       flush;
    word_t      redirect_pc;

    // expectations, sampled by the checkers at the next rising edge
    logic       exp_flush;
    word_t      exp_redirect;
    logic       chk_rdata;
    word_t      exp_rdata;
    logic       chk_mode;
    priv_mode_t exp_mode;
    logic       chk_lsu;
    priv_mode_t exp_lsu;

    int    errors;
    word_t wr_val;
    word_t mtvec_base;
    word_t stvec_base;
    word_t trap_pc;

    priv_unit priv_unit_i (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    flush_chk: assert property (@(posedge clk) disable iff (rst)
        flush == exp_flush)
        else begin
            errors++;
            $display("** Error: %0t: flush is %0b, expected %0b", $time, $sampled(flush),
                     exp_flush);
        end

    redirect_chk: assert property (@(posedge clk) disable iff (rst)
        exp_flush |-> (redirect_pc == exp_redirect))
        else begin
            errors++;
            $display("** Error: %0t: redirect_pc is %h, expected %h", $time,
                     $sampled(redirect_pc), exp_redirect);
        end

    rdata_chk: assert property (@(posedge clk) disable iff (rst)
        chk_rdata |-> (rdata == exp_rdata))
        else begin
            errors++;
            $display("** Error: %0t: csr %h reads %h, expected %h", $time, $sampled(raddr),
                     $sampled(rdata), exp_rdata);
        end

    mode_chk: assert property (@(posedge clk) disable iff (rst)
        chk_mode |-> (cpu_mode == exp_mode))
        else begin
            errors++;
            $display("** Error: %0t: cpu_mode is %0d, expected %0d", $time, $sampled(cpu_mode),
                     exp_mode);
        end

    lsu_chk: assert property (@(posedge clk) disable iff (rst)
        chk_lsu |-> (lsu_mode == exp_lsu))
        else begin
            errors++;
            $display("** Error: %0t: lsu_mode is %0d, expected %0d", $time, $sampled(lsu_mode),
                     exp_lsu);
        end

    task automatic idle_inputs;
        raddr        = '0;
        waddr        = '0;
        we           = 1'b0;
        wdata        = '0;
        exc_flags    = '0;
        mret         = 1'b0;
        sret         = 1'b0;
        inst         = '0;
        pc           = '0;
        mem_addr     = '0;
        timer_irq    = 1'b0;
        ext_irq      = 1'b0;
        exp_flush    = 1'b0;   // idle cycles must never flush
        exp_redirect = '0;
        chk_rdata    = 1'b0;
        chk_mode     = 1'b0;
        chk_lsu      = 1'b0;
    endtask

    // advance to the drive point just after the next rising edge
    task automatic step;
        @(posedge clk);
        #1;
        idle_inputs();
    endtask

    task automatic expect_redirect(input word_t target);
        exp_flush    = 1'b1;
        exp_redirect = target;
    endtask

    task automatic expect_mode(input priv_mode_t mode);
        chk_mode = 1'b1;
        exp_mode = mode;
    endtask

    task automatic csr_write(input csr_addr_t addr, input word_t data);
        waddr = addr;
        we    = 1'b1;
        wdata = data;
        pc    = $urandom;
        expect_redirect((pc & 32'hffff_fffc) + 32'd4);   // refetch next word
        step();
    endtask

    task automatic csr_read(input csr_addr_t addr, input word_t expected);
        raddr     = addr;
        chk_rdata = 1'b1;
        exp_rdata = expected;
        step();
    endtask

    task automatic drop_to_user(input word_t target);
        csr_write(`CSR_MSTATUS, 32'h0000_0000);   // mpp = U
        csr_write(`CSR_MEPC, target);
        mret = 1'b1;
        expect_redirect(target & `MEPC_WMASK);
        step();
    endtask

    initial begin
        void'($urandom(17226));
        errors = 0;
        rst    = 1'b1;
        idle_inputs();
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;
        step();

        $display("test 1: masked csr writes");
        wr_val = $urandom;
        csr_write(`CSR_MSCRATCH, wr_val);
        csr_read(`CSR_MSCRATCH, wr_val);
        wr_val = $urandom | 32'h0000_0800;   // keeps mpp off the reserved value
        csr_write(`CSR_MSTATUS, wr_val);
        csr_read(`CSR_MSTATUS, wr_val & `MSTATUS_WMASK);
        csr_read(`CSR_SSTATUS, wr_val & `MSTATUS_WMASK & `SSTATUS_RMASK);
        csr_write(`CSR_MSTATUS, `MSTATUS_INIT);

        $display("test 2: mret and illegal access");
        mtvec_base = $urandom & 32'hffff_fffc;
        csr_write(`CSR_MTVEC, mtvec_base);
        drop_to_user($urandom);
        raddr = `CSR_MSTATUS;   // machine csr from U
        inst  = csr_inst;
        pc    = $urandom & 32'hffff_fffc;
        expect_mode(MODE_U);
        expect_redirect(mtvec_base);
        step();
        expect_mode(MODE_M);
        csr_read(`CSR_MCAUSE, 32'd2);
        csr_read(`CSR_MTVAL, csr_inst);

        $display("test 3: delegated ecall and sret");
        stvec_base = $urandom & 32'hffff_fffc;
        csr_write(`CSR_MEDELEG, 32'h0000_0100);
        csr_write(`CSR_STVEC, stvec_base);
        drop_to_user($urandom);
        trap_pc = $urandom & 32'hffff_fffc;
        exc_flags[`EXC_BIT_ECALL] = 1'b1;
        pc = trap_pc;
        expect_mode(MODE_U);
        expect_redirect(stvec_base);
        step();
        expect_mode(MODE_S);
        csr_read(`CSR_SCAUSE, 32'd8);
        csr_read(`CSR_SEPC, trap_pc);
        sret = 1'b1;
        expect_redirect(trap_pc);
        step();
        raddr = `CSR_MSTATUS;   // back to M through an illegal read
        inst  = csr_inst;
        expect_mode(MODE_U);
        expect_redirect(mtvec_base);
        step();
        csr_write(`CSR_MSTATUS, 32'h0040_1800);   // tsr set
        sret = 1'b1;
        inst = csr_inst;
        expect_redirect(mtvec_base);
        step();
        expect_mode(MODE_M);
        csr_read(`CSR_MCAUSE, 32'd2);
        csr_write(`CSR_MSTATUS, `MSTATUS_INIT);

        $display("test 4: interrupts");
        mtvec_base = $urandom & 32'hffff_fffc;
        csr_write(`CSR_MTVEC, mtvec_base | 32'd1);   // vectored
        csr_write(`CSR_MIE, 32'h0000_0880);   // mtie and meie
        csr_write(`CSR_MSTATUS, 32'h0000_1808);
        timer_irq = 1'b1;
        ext_irq   = 1'b1;
        pc        = $urandom & 32'hffff_fffc;
        expect_redirect(mtvec_base + 32'd44);   // external wins, code 11
        step();
        csr_read(`CSR_MCAUSE, 32'h8000_0000 | 32'd11);
        timer_irq = 1'b1;   // mstatus.mie is clear after the trap
        ext_irq   = 1'b1;
        expect_mode(MODE_M);
        step();
        csr_write(`CSR_MIE, 32'h0000_0000);

        $display("test 5: store fault and mprv");
        exc_flags[`EXC_BIT_STORE_ACCESS_FAULT] = 1'b1;
        mem_addr = fault_addr;
        pc       = $urandom & 32'hffff_fffc;
        expect_redirect(mtvec_base);   // exceptions ignore vectoring
        step();
        csr_read(`CSR_MCAUSE, 32'd7);
        csr_read(`CSR_MTVAL, fault_addr);
        csr_write(`CSR_MSTATUS, 32'h0002_0800);   // mprv, mpp = S
        chk_lsu = 1'b1;
        exp_lsu = MODE_S;
        expect_mode(MODE_M);
        step();
        step();

        $display("run complete with %0d errors", errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    initial begin
        #((num_tests * test_cycles + reset_cycles) * clk_period);
        $display("watchdog expired, the tests did not finish in time");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* source/priv_unit.sv */
`timescale 1ns/1ps

module priv_unit import priv_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  csr_addr_t  raddr,
    input  csr_addr_t  waddr,
    input  logic       we,
    input  word_t      wdata,
    input  exc_flags_t exc_flags,
    input  logic       mret,
    input  logic       sret,
    input  word_t      inst,
    input  word_t      pc,
    input  word_t      mem_addr,
    input  logic       timer_irq,
    input  logic       ext_irq,
    output word_t      rdata,
    output priv_mode_t cpu_mode,
    output priv_mode_t lsu_mode,
    output logic       flush,
    output word_t      redirect_pc
);

    // commit strobes, trap_ctrl to csr_regfile
    logic        sw_write;
    logic        trap_take;
    logic        trap_to_s;
    logic        trap_is_irq;
    logic        mret_take;
    logic        sret_take;
    cause_code_t trap_cause;
    word_t       trap_tval;
    word_t       trap_epc;

    // register state fed back to the decision logic
    word_t mstatus;
    word_t mie;
    word_t mip_eff;
    word_t mideleg;
    word_t medeleg;
    word_t mtvec;
    word_t stvec;
    word_t mepc;
    word_t sepc;

    logic        irq_valid;
    cause_code_t irq_code;
    logic        irq_to_s;

    // port names match the nets above one to one
    csr_regfile csr_regfile_i (.*);

    trap_ctrl trap_ctrl_i (.*);

    irq_arbiter irq_arbiter_i (.*);

endmodule

/* csr/csr_regfile.sv */
`timescale 1ns/1ps
`include "priv_cfg.svh"

module csr_regfile import priv_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  csr_addr_t   raddr,
    input  csr_addr_t   waddr,
    input  word_t       wdata,
    input  logic        timer_irq,
    input  logic        ext_irq,
    input  logic        sw_write,
    input  logic        trap_take,
    input  logic        trap_to_s,
    input  logic        trap_is_irq,
    input  cause_code_t trap_cause,
    input  word_t       trap_tval,
    input  word_t       trap_epc,
    input  logic        mret_take,
    input  logic        sret_take,
    output word_t       rdata,
    output priv_mode_t  cpu_mode,
    output priv_mode_t  lsu_mode,
    output word_t       mstatus,
    output word_t       mie,
    output word_t       mip_eff,
    output word_t       mideleg,
    output word_t       medeleg,
    output word_t       mtvec,
    output word_t       stvec,
    output word_t       mepc,
    output word_t       sepc
);

    word_t mip;
    word_t mscratch;
    word_t mcause;
    word_t mtval;
    word_t sscratch;
    word_t scause;
    word_t stval;
    word_t mstatus_wr;
    word_t sstatus_wr;
    word_t sie_mask;
    word_t sip_mask;
    word_t cause_word;

    assign sie_mask   = `SIE_RWMASK & mideleg;
    assign sip_mask   = `SIP_RWMASK & mideleg;
    assign cause_word = {trap_is_irq, 27'b0, trap_cause};
    assign lsu_mode   = mstatus[`MSTATUS_MPRV] ? priv_mode_t'(mstatus[`MSTATUS_MPP]) : cpu_mode;

    // timer and external lines show up at both levels
    always_comb begin
        mip_eff = mip;
        mip_eff[`CAUSE_IRQ_M_TIMER] = mip[`CAUSE_IRQ_M_TIMER] | timer_irq;
        mip_eff[`CAUSE_IRQ_S_TIMER] = mip[`CAUSE_IRQ_S_TIMER] | timer_irq;
        mip_eff[`CAUSE_IRQ_M_EXT]   = mip[`CAUSE_IRQ_M_EXT] | ext_irq;
        mip_eff[`CAUSE_IRQ_S_EXT]   = mip[`CAUSE_IRQ_S_EXT] | ext_irq;
    end

    always_comb begin
        mstatus_wr = (mstatus & ~`MSTATUS_WMASK) | (wdata & `MSTATUS_WMASK);
        if (mstatus_wr[`MSTATUS_MPP] == 2'b10)
            mstatus_wr[`MSTATUS_MPP] = mstatus[`MSTATUS_MPP];  // reserved mpp, keep old
    end

    assign sstatus_wr = (mstatus & ~`SSTATUS_WMASK) | (wdata & `SSTATUS_WMASK);

    always_comb begin
        case (raddr)
            `CSR_SSTATUS:   rdata = mstatus & `SSTATUS_RMASK;
            `CSR_SIE:       rdata = mie & sie_mask;
            `CSR_SIP:       rdata = mip_eff & sip_mask;
            `CSR_STVEC:     rdata = stvec;
            `CSR_SSCRATCH:  rdata = sscratch;
            `CSR_SEPC:      rdata = sepc;
            `CSR_SCAUSE:    rdata = scause;
            `CSR_STVAL:     rdata = stval;
            `CSR_MSTATUS:   rdata = mstatus;
            `CSR_MISA:      rdata = `MISA_INIT;
            `CSR_MEDELEG:   rdata = medeleg;
            `CSR_MIDELEG:   rdata = mideleg;
            `CSR_MIE:       rdata = mie;
            `CSR_MTVEC:     rdata = mtvec;
            `CSR_MSCRATCH:  rdata = mscratch;
            `CSR_MEPC:      rdata = mepc;
            `CSR_MCAUSE:    rdata = mcause;
            `CSR_MTVAL:     rdata = mtval;
            `CSR_MIP:       rdata = mip_eff;
            `CSR_MVENDORID: rdata = `MVENDORID_INIT;
            `CSR_MARCHID:   rdata = `MARCHID_INIT;
            `CSR_MIMPID:    rdata = `MIMPID_INIT;
            `CSR_MHARTID:   rdata = `MHARTID_INIT;
            default:        rdata = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_mode <= MODE_M;
            mstatus  <= `MSTATUS_INIT;
            mie      <= '0;
            mip      <= '0;
            medeleg  <= '0;
            mideleg  <= '0;
            mtvec    <= '0;
            stvec    <= '0;
        end else if (trap_take) begin
            if (trap_to_s) begin
                mstatus[`MSTATUS_SPIE] <= mstatus[`MSTATUS_SIE];
                mstatus[`MSTATUS_SIE]  <= 1'b0;
                mstatus[`MSTATUS_SPP]  <= cpu_mode[0];
                cpu_mode <= MODE_S;
            end else begin
                mstatus[`MSTATUS_MPIE] <= mstatus[`MSTATUS_MIE];
                mstatus[`MSTATUS_MIE]  <= 1'b0;
                mstatus[`MSTATUS_MPP]  <= cpu_mode;
                cpu_mode <= MODE_M;
            end
        end else if (mret_take) begin
            mstatus[`MSTATUS_MIE]  <= mstatus[`MSTATUS_MPIE];
            mstatus[`MSTATUS_MPIE] <= 1'b1;
            mstatus[`MSTATUS_MPP]  <= MODE_U;
            if (mstatus[`MSTATUS_MPP] != MODE_M)
                mstatus[`MSTATUS_MPRV] <= 1'b0;
            cpu_mode <= priv_mode_t'(mstatus[`MSTATUS_MPP]);
        end else if (sret_take) begin
            mstatus[`MSTATUS_SIE]  <= mstatus[`MSTATUS_SPIE];
            mstatus[`MSTATUS_SPIE] <= 1'b1;
            mstatus[`MSTATUS_SPP]  <= 1'b0;
            cpu_mode <= priv_mode_t'({1'b0, mstatus[`MSTATUS_SPP]});
        end else if (sw_write) begin
            case (waddr)
                `CSR_MSTATUS: mstatus <= mstatus_wr;
                `CSR_SSTATUS: mstatus <= sstatus_wr;
                `CSR_MEDELEG: medeleg <= wdata & `MEDELEG_WMASK;
                `CSR_MIDELEG: mideleg <= wdata & `MIDELEG_WMASK;
                `CSR_MIE:     mie <= wdata & `MIE_WMASK;
                `CSR_SIE:     mie <= (mie & ~sie_mask) | (wdata & sie_mask);
                `CSR_MIP:     mip <= wdata & `MIP_WMASK;
                `CSR_SIP:     mip <= (mip & ~sip_mask) | (wdata & sip_mask);
                `CSR_MTVEC:   mtvec <= {wdata[31:2], 1'b0, wdata[0]};  // direct or vectored
                `CSR_STVEC:   stvec <= {wdata[31:2], 1'b0, wdata[0]};
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (trap_take) begin
            if (trap_to_s) begin
                sepc   <= trap_epc & `MEPC_WMASK;
                scause <= cause_word;
                stval  <= trap_tval;
            end else begin
                mepc   <= trap_epc & `MEPC_WMASK;
                mcause <= cause_word;
                mtval  <= trap_tval;
            end
        end else if (sw_write) begin
            case (waddr)
                `CSR_MSCRATCH: mscratch <= wdata;
                `CSR_MEPC:     mepc <= wdata & `MEPC_WMASK;
                `CSR_MCAUSE:   mcause <= wdata;
                `CSR_MTVAL:    mtval <= wdata;
                `CSR_SSCRATCH: sscratch <= wdata;
                `CSR_SEPC:     sepc <= wdata & `MEPC_WMASK;
                `CSR_SCAUSE:   scause <= wdata;
                `CSR_STVAL:    stval <= wdata;
                default: ;
            endcase
        end
    end

    strobe_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({trap_take, mret_take, sret_take, sw_write}))
        else $error("more than one commit strobe in a cycle");

    // mpp legalisation keeps mret from ever landing here
    mode_legal: assert property (@(posedge clk) disable iff (rst) cpu_mode != 2'b10)
        else $error("cpu_mode holds the reserved encoding");

endmodule

/* csr/trap_ctrl.sv */
`timescale 1ns/1ps
`include "priv_cfg.svh"

module trap_ctrl import priv_pkg::*; (
    input  csr_addr_t   raddr,
    input  csr_addr_t   waddr,
    input  logic        we,
    input  exc_flags_t  exc_flags,
    input  logic        mret,
    input  logic        sret,
    input  word_t       inst,
    input  word_t       pc,
    input  word_t       mem_addr,
    input  priv_mode_t  cpu_mode,
    input  word_t       mstatus,
    input  word_t       medeleg,
    input  word_t       mtvec,
    input  word_t       stvec,
    input  word_t       mepc,
    input  word_t       sepc,
    input  logic        irq_valid,
    input  cause_code_t irq_code,
    input  logic        irq_to_s,
    output logic        sw_write,
    output logic        trap_take,
    output logic        trap_to_s,
    output logic        trap_is_irq,
    output cause_code_t trap_cause,
    output word_t       trap_tval,
    output word_t       trap_epc,
    output logic        mret_take,
    output logic        sret_take,
    output logic        flush,
    output word_t       redirect_pc
);

    logic        csr_illegal;
    exc_flags_t  exc;
    cause_code_t exc_code;
    word_t       exc_tval;
    word_t       tvec;

    // read-only space, privilege field above the mode, or sret under tsr
    assign csr_illegal = (we && waddr[11:10] == 2'b11)
                      || (we && cpu_mode < waddr[9:8])
                      || (cpu_mode < raddr[9:8])
                      || (sret && mstatus[`MSTATUS_TSR]);

    always_comb begin
        exc = exc_flags;
        exc[`EXC_BIT_ILLEGAL_INST] = exc_flags[`EXC_BIT_ILLEGAL_INST] | csr_illegal;
    end

    always_comb begin
        exc_code = '0;
        exc_tval = '0;
        if (exc[`EXC_BIT_BREAKPOINT]) begin
            exc_code = `CAUSE_BREAKPOINT;
            exc_tval = pc;
        end else if (exc[`EXC_BIT_FETCH_ACCESS_FAULT]) begin
            exc_code = `CAUSE_FETCH_ACCESS;
            exc_tval = pc;
        end else if (exc[`EXC_BIT_ILLEGAL_INST]) begin
            exc_code = `CAUSE_ILLEGAL_INST;
            exc_tval = inst;
        end else if (exc[`EXC_BIT_FETCH_MISALIGN]) begin
            exc_code = `CAUSE_FETCH_MISALIGN;
            exc_tval = pc;
        end else if (exc[`EXC_BIT_ECALL]) begin
            case (cpu_mode)
                MODE_U:  exc_code = `CAUSE_ECALL_U;
                MODE_S:  exc_code = `CAUSE_ECALL_S;
                default: exc_code = `CAUSE_ECALL_M;
            endcase
        end else if (exc[`EXC_BIT_STORE_MISALIGN]) begin
            exc_code = `CAUSE_STORE_MISALIGN;
            exc_tval = mem_addr;
        end else if (exc[`EXC_BIT_LOAD_MISALIGN]) begin
            exc_code = `CAUSE_LOAD_MISALIGN;
            exc_tval = mem_addr;
        end else if (exc[`EXC_BIT_STORE_ACCESS_FAULT]) begin
            exc_code = `CAUSE_STORE_ACCESS;
            exc_tval = mem_addr;
        end else if (exc[`EXC_BIT_LOAD_ACCESS_FAULT]) begin
            exc_code = `CAUSE_LOAD_ACCESS;
            exc_tval = mem_addr;
        end
    end

    // an interrupt beats any exception
    assign trap_take   = irq_valid || (|exc);
    assign trap_is_irq = irq_valid;
    assign trap_cause  = irq_valid ? irq_code : exc_code;
    assign trap_tval   = irq_valid ? '0 : exc_tval;
    assign trap_epc    = pc;
    assign trap_to_s   = irq_valid ? irq_to_s : (cpu_mode != MODE_M && medeleg[exc_code]);

    assign mret_take = mret && !trap_take;
    assign sret_take = sret && !trap_take && !mret;
    assign sw_write  = we && !trap_take && !mret && !sret;
    assign flush     = trap_take || mret_take || sret_take || sw_write;

    assign tvec = trap_to_s ? stvec : mtvec;

    always_comb begin
        if (trap_take) begin
            redirect_pc = {tvec[31:2], 2'b00};
            if (tvec[1:0] == 2'b01 && trap_is_irq)
                redirect_pc = redirect_pc + {26'b0, trap_cause, 2'b00};  // vectored
        end else if (mret_take) begin
            redirect_pc = mepc;
        end else if (sret_take) begin
            redirect_pc = sepc;
        end else begin
            redirect_pc = {pc[31:2] + 30'd1, 2'b00};  // refetch after csr write
        end
    end

    // epc registers are kept word aligned by the register block
    always_comb begin
        if (flush)
            assert (redirect_pc[1:0] == 2'b00)
                else $error("flush with misaligned redirect_pc %h", redirect_pc);
    end

endmodule

/* csr/irq_arbiter.sv */
`timescale 1ns/1ps
`include "priv_cfg.svh"

module irq_arbiter import priv_pkg::*; (
    input  word_t       mip_eff,
    input  word_t       mie,
    input  word_t       mideleg,
    input  word_t       mstatus,
    input  priv_mode_t  cpu_mode,
    output logic        irq_valid,
    output cause_code_t irq_code,
    output logic        irq_to_s
);

    logic       m_en;
    logic       s_en;
    word_t      pend;
    logic [5:0] take;   // mei msi mti sei ssi sti

    assign m_en = (cpu_mode != MODE_M) || mstatus[`MSTATUS_MIE];
    assign s_en = (cpu_mode == MODE_U) || (cpu_mode == MODE_S && mstatus[`MSTATUS_SIE]);
    assign pend = mip_eff & mie;

    // s-level sources fall back to the m enable unless delegated
    assign take = {
        pend[`CAUSE_IRQ_M_EXT]   & m_en,
        pend[`CAUSE_IRQ_M_SOFT]  & m_en,
        pend[`CAUSE_IRQ_M_TIMER] & m_en,
        pend[`CAUSE_IRQ_S_EXT]   & (mideleg[`CAUSE_IRQ_S_EXT] ? s_en : m_en),
        pend[`CAUSE_IRQ_S_SOFT]  & (mideleg[`CAUSE_IRQ_S_SOFT] ? s_en : m_en),
        pend[`CAUSE_IRQ_S_TIMER] & (mideleg[`CAUSE_IRQ_S_TIMER] ? s_en : m_en)
    };

    always_comb begin
        casez (take)
            6'b1?????: irq_code = `CAUSE_IRQ_M_EXT;
            6'b01????: irq_code = `CAUSE_IRQ_M_SOFT;
            6'b001???: irq_code = `CAUSE_IRQ_M_TIMER;
            6'b0001??: irq_code = `CAUSE_IRQ_S_EXT;
            6'b00001?: irq_code = `CAUSE_IRQ_S_SOFT;
            6'b000001: irq_code = `CAUSE_IRQ_S_TIMER;
            default:   irq_code = '0;
        endcase
    end

    assign irq_valid = |take;
    assign irq_to_s  = irq_valid && mideleg[irq_code] && (cpu_mode != MODE_M);

endmodule

/* common/priv_pkg.sv */
package priv_pkg;

    typedef logic [31:0] word_t;        // data, pc, inst, address
    typedef logic [11:0] csr_addr_t;
    typedef logic [3:0]  cause_code_t;  // trap code, interrupt bit kept apart
    typedef logic [8:0]  exc_flags_t;   // one bit per exception, see EXC_BIT_*

    typedef enum logic [1:0] {
        MODE_U = 2'd0,
        MODE_S = 2'd1,
        MODE_M = 2'd3
    } priv_mode_t;

endpackage

/* common/priv_cfg.svh */
`ifndef PRIV_CFG_SVH
`define PRIV_CFG_SVH

// positions in exc_flags_t
`define EXC_BIT_BREAKPOINT         0
`define EXC_BIT_FETCH_MISALIGN     1
`define EXC_BIT_FETCH_ACCESS_FAULT 2
`define EXC_BIT_ILLEGAL_INST       3
`define EXC_BIT_ECALL              4
`define EXC_BIT_LOAD_MISALIGN      5
`define EXC_BIT_STORE_MISALIGN     6
`define EXC_BIT_LOAD_ACCESS_FAULT  7
`define EXC_BIT_STORE_ACCESS_FAULT 8

// supervisor csrs
`define CSR_SSTATUS   12'h100
`define CSR_SIE       12'h104
`define CSR_STVEC     12'h105
`define CSR_SSCRATCH  12'h140
`define CSR_SEPC      12'h141
`define CSR_SCAUSE    12'h142
`define CSR_STVAL     12'h143
`define CSR_SIP       12'h144

// machine csrs
`define CSR_MSTATUS   12'h300
`define CSR_MISA      12'h301
`define CSR_MEDELEG   12'h302
`define CSR_MIDELEG   12'h303
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MTVAL     12'h343
`define CSR_MIP       12'h344
`define CSR_MVENDORID 12'hf11
`define CSR_MARCHID   12'hf12
`define CSR_MIMPID    12'hf13
`define CSR_MHARTID   12'hf14

`define CAUSE_FETCH_MISALIGN 4'd0
`define CAUSE_FETCH_ACCESS   4'd1
`define CAUSE_ILLEGAL_INST   4'd2
`define CAUSE_BREAKPOINT     4'd3
`define CAUSE_LOAD_MISALIGN  4'd4
`define CAUSE_LOAD_ACCESS    4'd5
`define CAUSE_STORE_MISALIGN 4'd6
`define CAUSE_STORE_ACCESS   4'd7
`define CAUSE_ECALL_U        4'd8
`define CAUSE_ECALL_S        4'd9
`define CAUSE_ECALL_M        4'd11

// interrupt codes double as the mip/mie bit index
`define CAUSE_IRQ_S_SOFT  4'd1
`define CAUSE_IRQ_M_SOFT  4'd3
`define CAUSE_IRQ_S_TIMER 4'd5
`define CAUSE_IRQ_M_TIMER 4'd7
`define CAUSE_IRQ_S_EXT   4'd9
`define CAUSE_IRQ_M_EXT   4'd11

`define MSTATUS_SIE  1
`define MSTATUS_MIE  3
`define MSTATUS_SPIE 5
`define MSTATUS_MPIE 7
`define MSTATUS_SPP  8
`define MSTATUS_MPP  12:11   // bit range
`define MSTATUS_MPRV 17
`define MSTATUS_TSR  22

`define MSTATUS_WMASK 32'h006e_19aa
`define SSTATUS_RMASK 32'h000c_0122
`define SSTATUS_WMASK 32'h000c_0122
`define MIE_WMASK     32'h0000_0aaa
`define SIE_RWMASK    32'h0000_0222
`define MIP_WMASK     32'h0000_022a
`define SIP_RWMASK    32'h0000_0222
`define MEDELEG_WMASK 32'h0000_03ff
`define MIDELEG_WMASK 32'h0000_0222
`define MEPC_WMASK    32'hffff_fffc

`define MSTATUS_INIT   32'h0000_1800
`define MISA_INIT      32'h4014_1101   // rv32 i m a s u
`define MVENDORID_INIT 32'h0000_0000
`define MARCHID_INIT   32'h0000_0000
`define MIMPID_INIT    32'h0000_0001
`define MHARTID_INIT   32'h0000_0000

`endif
